//--- Bender.yml
package:
  name: spi_master

sources:
  - include_dirs:
      - common
    files:
      - common/spi_pkg.sv
      - common/spi_sck_if.sv
      - common/spi_timer_if.sv
      - hw/spi_sck_gen.sv
      - hw/spi_frame_timer.sv
      - spi_shift_seq/spi_shift_seq.sv
      - hw/spi_master.sv
  - target: test
    include_dirs:
      - common
      - verif
    files:
      - verif/tb_spi_master.sv

//--- common/spi_consts.svh
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

//////////////////////////////
// frame and delay widths
//////////////////////////////

`define SPI_WORD_W  32          // widest frame, bits
`define SPI_DELAY_W 8           // gap and cs delay settings

//////////////////////////////
// sck half periods
//////////////////////////////

// half period in gclk cycles, one per sck_speed code
`define SPI_HALF_128 64         // code 0
`define SPI_HALF_64  32         // code 1
`define SPI_HALF_32  16         // code 2
`define SPI_HALF_16  8          // code 3

//////////////////////////////
// word lengths
//////////////////////////////

// bits per frame, one per word_len code
`define SPI_LEN_32 32           // code 0
`define SPI_LEN_16 16           // code 1
`define SPI_LEN_8  8            // code 2
`define SPI_LEN_4  4            // code 3

`endif

//--- common/spi_pkg.sv
`include "spi_consts.svh"

package spi_pkg;

    //////////////////////////////
    // vector types
    //////////////////////////////

    // one data word, short frames sit in the low bits
    typedef logic [`SPI_WORD_W-1:0] spi_word_t;

    typedef logic [`SPI_DELAY_W-1:0] spi_delay_t;   // gap or delay, gclk cycles

    // must hold the longest half period minus one
    typedef logic [$clog2(`SPI_HALF_128):0] spi_div_cnt_t;

    // edges left in a frame minus one, also wide enough for the bit count
    typedef logic [$clog2(`SPI_WORD_W):0] spi_bit_cnt_t;

    //////////////////////////////
    // sequencer states
    //////////////////////////////

    typedef enum logic [2:0] {
        IDLE,                       // waiting for a start edge
        GAP,                        // start taken, interframe gap not over yet
        LEAD,                       // cs low, waiting for the first sck edge
        SHIFT,                      // sck running
        LAG                         // last edge done, waiting to raise cs
    } seq_state_e;

endpackage

//--- common/spi_sck_if.sv
interface spi_sck_if ();

    logic       run;                // sck toggles while high
    logic       first_edge;         // kicks off the first edge one cycle later
    logic       cpol;               // idle sck level
    logic [1:0] half_sel;           // rate code of the current frame
    logic       lead_edge_next;     // sck leaves idle level next cycle
    logic       trail_edge_next;    // sck returns to idle level next cycle

    // sequencer side
    modport seq (
        output run,
        output first_edge,
        output cpol,
        output half_sel,
        input  lead_edge_next,
        input  trail_edge_next
    );

    modport gen (
        input  run,
        input  first_edge,
        input  cpol,
        input  half_sel,
        output lead_edge_next,
        output trail_edge_next
    );

endinterface

//--- common/spi_timer_if.sv
interface spi_timer_if import spi_pkg::*; ();

    logic       lead_go;            // cs just went low, start cs-to-sck delay
    logic       lag_go;             // last edge seen, start sck-to-cs delay
    spi_delay_t lead_delay;
    spi_delay_t lag_delay;
    logic       gap_ok;             // interframe gap has elapsed
    logic       lead_done;
    logic       lag_done;

    modport seq (
        output lead_go,
        output lag_go,
        output lead_delay,
        output lag_delay,
        input  gap_ok,
        input  lead_done,
        input  lag_done
    );

    modport timer (
        input  lead_go,
        input  lag_go,
        input  lead_delay,
        input  lag_delay,
        output gap_ok,
        output lead_done,
        output lag_done
    );

endinterface

//--- hw/spi_frame_timer.sv
module spi_frame_timer import spi_pkg::*; (
    input  logic        gclk_i,
    input  logic        nrst_i,
    input  spi_delay_t  ifg_i,          // minimum gap between frames
    spi_timer_if.timer  tmr
);

    spi_delay_t gap_cnt_q;          // cycles since the last frame ended, saturating
    spi_delay_t dly_cnt_q;
    spi_delay_t dly_target;
    logic       dly_busy_q;         // a lead or lag delay is running
    logic       dly_lag_q;          // running delay belongs to the lag phase
    logic       dly_hit;

    //////////////////////////////
    // interframe gap
    //////////////////////////////

    assign tmr.gap_ok = (gap_cnt_q >= ifg_i);

    always_ff @(posedge gclk_i) begin
        if (!nrst_i) begin
            gap_cnt_q <= '0;
        end else if (tmr.lag_done) begin
            gap_cnt_q <= '0;            // cs rises now, gap counts from here
        end else if (gap_cnt_q != '1) begin
            gap_cnt_q <= gap_cnt_q + 1'b1;
        end
    end

    //////////////////////////////
    // cs delays
    //////////////////////////////

    // lead and lag never overlap, so one counter serves both
    assign dly_target = dly_lag_q ? tmr.lag_delay : tmr.lead_delay;

    // count starts at 1, so a zero setting behaves like 1
    assign dly_hit = dly_busy_q & (dly_cnt_q >= dly_target);

    assign tmr.lead_done = dly_hit & ~dly_lag_q;
    assign tmr.lag_done  = dly_hit & dly_lag_q;

    always_ff @(posedge gclk_i) begin
        if (!nrst_i) begin
            dly_busy_q <= 1'b0;
            dly_lag_q  <= 1'b0;
            dly_cnt_q  <= '0;
        end else if (tmr.lead_go || tmr.lag_go) begin
            dly_busy_q <= 1'b1;
            dly_lag_q  <= tmr.lag_go;
            dly_cnt_q  <= spi_delay_t'(1);
        end else if (dly_hit) begin
            dly_busy_q <= 1'b0;         // done pulse lasts one cycle
        end else if (dly_busy_q) begin
            dly_cnt_q  <= dly_cnt_q + 1'b1;
        end
    end

endmodule

//--- hw/spi_master.sv
module spi_master import spi_pkg::*; (
    input  logic       gclk_i,
    input  logic       nrst_i,

    // control
    input  logic       start_i,          // rising edge starts a frame
    output logic       busy_o,

    // frame configuration, latched at the start edge
    input  logic [1:0] spi_mode_i,       // {cpol, cpha}
    input  logic [1:0] sck_speed_i,      // gclk/128, /64, /32, /16
    input  logic [1:0] word_len_i,       // 32, 16, 8, 4 bits
    input  spi_delay_t ifg_i,
    input  spi_delay_t cs_sck_i,
    input  spi_delay_t sck_cs_i,

    // data words
    input  spi_word_t  mosi_data_i,
    output spi_word_t  miso_data_o,

    // spi bus
    input  logic       miso_i,
    output logic       mosi_o,
    output logic       sclk_o,
    output logic       cs_o
);

    spi_sck_if   i_sck_if ();
    spi_timer_if i_tmr_if ();

    spi_sck_gen i_sck_gen (
        .gclk_i (gclk_i),
        .nrst_i (nrst_i),
        .sck    (i_sck_if.gen),
        .sclk_o (sclk_o)
    );

    spi_frame_timer i_frame_timer (
        .gclk_i (gclk_i),
        .nrst_i (nrst_i),
        .ifg_i  (ifg_i),
        .tmr    (i_tmr_if.timer)
    );

    spi_shift_seq i_shift_seq (
        .gclk_i      (gclk_i),
        .nrst_i      (nrst_i),
        .start_i     (start_i),
        .spi_mode_i  (spi_mode_i),
        .sck_speed_i (sck_speed_i),
        .word_len_i  (word_len_i),
        .cs_sck_i    (cs_sck_i),
        .sck_cs_i    (sck_cs_i),
        .mosi_data_i (mosi_data_i),
        .miso_i      (miso_i),
        .sck         (i_sck_if.seq),
        .tmr         (i_tmr_if.seq),
        .busy_o      (busy_o),
        .miso_data_o (miso_data_o),
        .mosi_o      (mosi_o),
        .cs_o        (cs_o)
    );

endmodule

//--- hw/spi_sck_gen.sv
`include "spi_consts.svh"

module spi_sck_gen import spi_pkg::*; (
    input  logic   gclk_i,
    input  logic   nrst_i,
    spi_sck_if.gen sck,
    output logic   sclk_o
);

    spi_div_cnt_t div_cnt_q;        // gclk cycles into the current half period
    spi_div_cnt_t half_last;        // count value at which sck toggles
    logic         edge_now;         // sck toggles at the end of this cycle

    //////////////////////////////
    // rate decode
    //////////////////////////////

    always_comb begin
        unique case (sck.half_sel)
            2'd0: half_last = spi_div_cnt_t'(`SPI_HALF_128 - 1);
            2'd1: half_last = spi_div_cnt_t'(`SPI_HALF_64 - 1);
            2'd2: half_last = spi_div_cnt_t'(`SPI_HALF_32 - 1);
            2'd3: half_last = spi_div_cnt_t'(`SPI_HALF_16 - 1);
        endcase
    end

    //////////////////////////////
    // edge announce
    //////////////////////////////

    // the first edge is requested by the sequencer, the rest come from the divider
    assign edge_now = sck.first_edge | (sck.run & (div_cnt_q == half_last));

    // sck still at idle level means the coming edge leaves it
    assign sck.lead_edge_next  = edge_now & (sclk_o == sck.cpol);
    assign sck.trail_edge_next = edge_now & (sclk_o != sck.cpol);

    //////////////////////////////
    // divider and sck level
    //////////////////////////////

    always_ff @(posedge gclk_i) begin
        if (!nrst_i) begin
            sclk_o    <= 1'b0;
            div_cnt_q <= '0;
        end else if (edge_now) begin
            sclk_o    <= ~sclk_o;
            div_cnt_q <= '0;            // new half period starts
        end else if (sck.run) begin
            div_cnt_q <= div_cnt_q + 1'b1;
        end else begin
            // parked between frames
            sclk_o    <= sck.cpol;
            div_cnt_q <= '0;
        end
    end

endmodule

//--- sources.f
+incdir+common
+incdir+verif
common/spi_pkg.sv
common/spi_sck_if.sv
common/spi_timer_if.sv
hw/spi_sck_gen.sv
hw/spi_frame_timer.sv
spi_shift_seq/spi_shift_seq.sv
hw/spi_master.sv
verif/tb_spi_master.sv

//--- spi_shift_seq/spi_shift_seq.sv
`include "spi_consts.svh"

module spi_shift_seq import spi_pkg::*; (
    input  logic       gclk_i,
    input  logic       nrst_i,
    input  logic       start_i,
    input  logic [1:0] spi_mode_i,
    input  logic [1:0] sck_speed_i,
    input  logic [1:0] word_len_i,
    input  spi_delay_t cs_sck_i,
    input  spi_delay_t sck_cs_i,
    input  spi_word_t  mosi_data_i,
    input  logic       miso_i,
    spi_sck_if.seq     sck,
    spi_timer_if.seq   tmr,
    output logic       busy_o,
    output spi_word_t  miso_data_o,
    output logic       mosi_o,
    output logic       cs_o
);

    seq_state_e   state_q;
    logic         start_q;
    logic         start_edge;
    logic         run_q;
    logic         cpol_q;
    logic         cpha_q;
    logic [1:0]   half_sel_q;
    spi_delay_t   lead_dly_q;
    spi_delay_t   lag_dly_q;
    spi_bit_cnt_t len_dec;          // bits in the requested frame
    spi_bit_cnt_t edge_cnt_q;       // edges left minus one
    spi_word_t    mosi_sr_q;        // next bit to send always in the msb
    spi_word_t    miso_sr_q;
    logic         in_frame;
    logic         last_edge;
    logic         load_first;
    logic         shift_out;
    logic         sample_in;

    //////////////////////////////
    // event decode
    //////////////////////////////

    always_comb begin
        unique case (word_len_i)
            2'd0: len_dec = spi_bit_cnt_t'(`SPI_LEN_32);
            2'd1: len_dec = spi_bit_cnt_t'(`SPI_LEN_16);
            2'd2: len_dec = spi_bit_cnt_t'(`SPI_LEN_8);
            2'd3: len_dec = spi_bit_cnt_t'(`SPI_LEN_4);
        endcase
    end

    assign start_edge = start_i & ~start_q & (state_q == IDLE);   // ignored mid-frame
    assign in_frame   = (state_q == LEAD) | (state_q == SHIFT);
    assign last_edge  = (state_q == SHIFT) & sck.trail_edge_next & (edge_cnt_q == '0);

    // phase 0 puts the first bit out together with cs falling
    assign load_first = tmr.lead_go & ~cpha_q;
    assign shift_out  = in_frame & (cpha_q ? sck.lead_edge_next : sck.trail_edge_next);
    assign sample_in  = in_frame & (cpha_q ? sck.trail_edge_next : sck.lead_edge_next);

    assign sck.run        = run_q;
    assign sck.first_edge = (state_q == LEAD) & tmr.lead_done;
    assign sck.cpol       = (state_q == IDLE) ? spi_mode_i[1] : cpol_q;
    assign sck.half_sel   = half_sel_q;

    assign tmr.lead_go    = (state_q == GAP) & tmr.gap_ok;
    assign tmr.lag_go     = last_edge;
    assign tmr.lead_delay = lead_dly_q;
    assign tmr.lag_delay  = lag_dly_q;

    //////////////////////////////
    // frame FSM
    //////////////////////////////

    always_ff @(posedge gclk_i) begin
        if (!nrst_i) begin
            state_q     <= IDLE;
            start_q     <= 1'b0;
            run_q       <= 1'b0;
            busy_o      <= 1'b0;
            cs_o        <= 1'b1;
            mosi_o      <= 1'b0;
            miso_data_o <= '0;
        end else begin
            start_q <= start_i;

            if (sck.first_edge) begin
                run_q <= 1'b1;
            end else if (last_edge) begin
                run_q <= 1'b0;                  // stops right after the last edge
            end

            if (load_first || shift_out) begin
                mosi_o <= mosi_sr_q[`SPI_WORD_W-1];
            end else if (tmr.lag_done) begin
                mosi_o <= 1'b0;
            end

            case (state_q)
                IDLE: begin
                    if (start_edge) state_q <= GAP;
                end
                GAP: begin
                    if (tmr.gap_ok) begin
                        cs_o    <= 1'b0;
                        busy_o  <= 1'b1;
                        state_q <= LEAD;
                    end
                end
                LEAD: begin
                    if (tmr.lead_done) state_q <= SHIFT;
                end
                SHIFT: begin
                    if (last_edge) state_q <= LAG;
                end
                LAG: begin
                    if (tmr.lag_done) begin
                        cs_o        <= 1'b1;
                        busy_o      <= 1'b0;
                        miso_data_o <= miso_sr_q;
                        state_q     <= IDLE;
                    end
                end
            endcase
        end
    end

    //////////////////////////////
    // shift registers
    //////////////////////////////

    always_ff @(posedge gclk_i) begin
        if (start_edge) begin
            cpol_q     <= spi_mode_i[1];
            cpha_q     <= spi_mode_i[0];
            half_sel_q <= sck_speed_i;
            lead_dly_q <= cs_sck_i;
            lag_dly_q  <= sck_cs_i;
            edge_cnt_q <= spi_bit_cnt_t'(2 * len_dec - 1);        // 2N edges per frame
            mosi_sr_q  <= mosi_data_i << (`SPI_WORD_W - len_dec);  // bit N-1 to the top
            miso_sr_q  <= '0;                                      // zero-extends short words
        end else begin
            if (load_first || shift_out) mosi_sr_q <= mosi_sr_q << 1;
            if (sample_in) miso_sr_q <= {miso_sr_q[`SPI_WORD_W-2:0], miso_i};
            if (in_frame && (sck.lead_edge_next || sck.trail_edge_next)) begin
                edge_cnt_q <= edge_cnt_q - 1'b1;
            end
        end
    end

endmodule

//--- verif/spi_tb_vectors.svh
`ifndef SPI_TB_VECTORS_SVH
`define SPI_TB_VECTORS_SVH

typedef struct packed {
    logic [1:0] mode;               // {cpol, cpha}
    logic [1:0] rate;               // sck_speed code
    logic [1:0] len;                // word_len code
    spi_delay_t ifg;
    spi_delay_t cs_sck;
    spi_delay_t sck_cs;
    spi_word_t  mosi_word;
    spi_word_t  reply_word;         // sent back by the slave model
    logic [7:0] half;               // expected sck half period in gclk cycles
    spi_word_t  exp_rx;             // reply word masked to the frame length
} vec_t;

localparam int NUM_VEC = 8;

vec_t vec_tbl [NUM_VEC];

// mode, rate, len, ifg, cs_sck, sck_cs, mosi word, reply word, half period, expected rx
task automatic load_vectors();
    vec_tbl[0] = {2'd0, 2'd0, 2'd0, 8'd0, 8'd0, 8'd0,
                  32'h12345678, 32'h9abcdef0, 8'd64, 32'h9abcdef0};
    vec_tbl[1] = {2'd1, 2'd3, 2'd1, 8'd12, 8'd1, 8'd2,
                  32'hdeadbeef, 32'h0f1e2d3c, 8'd8, 32'h00002d3c};
    vec_tbl[2] = {2'd2, 2'd2, 2'd2, 8'd40, 8'd5, 8'd0,
                  32'ha5a55a5a, 32'h80000081, 8'd16, 32'h00000081};
    vec_tbl[3] = {2'd3, 2'd1, 2'd3, 8'd3, 8'd255, 8'd9,
                  32'h00000001, 32'hfffffffe, 8'd32, 32'h0000000e};
    vec_tbl[4] = {2'd0, 2'd3, 2'd3, 8'd25, 8'd2, 8'd7,
                  32'hcafe1239, 32'h5555c3a7, 8'd8, 32'h00000007};
    vec_tbl[5] = {2'd1, 2'd2, 2'd0, 8'd0, 8'd0, 8'd255,
                  32'h00008001, 32'habcd7e11, 8'd16, 32'habcd7e11};
    vec_tbl[6] = {2'd2, 2'd1, 2'd1, 8'd60, 8'd31, 8'd1,
                  32'hffff0000, 32'h1111ffff, 8'd32, 32'h0000ffff};
    vec_tbl[7] = {2'd3, 2'd0, 2'd2, 8'd100, 8'd3, 8'd3,
                  32'h2468ace0, 32'h0bad8642, 8'd64, 32'h00000042};
endtask

`endif

//--- verif/tb_spi_master.sv
module tb_spi_master import spi_pkg::*; ();

    logic       gclk;
    logic       nrst;
    logic       start;
    logic [1:0] spi_mode;
    logic [1:0] sck_speed;
    logic [1:0] word_len;
    spi_delay_t ifg;
    spi_delay_t cs_sck;
    spi_delay_t sck_cs;
    spi_word_t  mosi_data;
    logic       miso;
    logic       busy;
    spi_word_t  miso_data;
    logic       mosi;
    logic       sclk;
    logic       cs;

    `include "spi_tb_vectors.svh"

    // row in flight as seen by the slave model and the monitor
    logic       cur_cpol;
    logic       cur_cpha;
    int         cur_bits;
    int         cur_half;
    int         cur_ifg;
    int         cur_lead;           // cs fall to first edge
    int         cur_lag;            // last edge to cs rise
    spi_word_t  cur_reply;

    int         data_errs;
    int         timing_errs;
    int         timeouts;

    logic       cs_d;
    logic       sclk_d;
    int         cyc;
    int         fall_cyc;
    int         rise_cyc;
    logic       rise_seen;
    int         last_edge_cyc;
    int         edges_seen;
    int         frames_seen;
    int         tx_left;            // reply bits not yet on miso
    spi_word_t  slave_rx;

    spi_master i_spi_master (
        .gclk_i      (gclk),
        .nrst_i      (nrst),
        .start_i     (start),
        .busy_o      (busy),
        .spi_mode_i  (spi_mode),
        .sck_speed_i (sck_speed),
        .word_len_i  (word_len),
        .ifg_i       (ifg),
        .cs_sck_i    (cs_sck),
        .sck_cs_i    (sck_cs),
        .mosi_data_i (mosi_data),
        .miso_data_o (miso_data),
        .miso_i      (miso),
        .mosi_o      (mosi),
        .sclk_o      (sclk),
        .cs_o        (cs)
    );

    always #10 gclk = ~gclk;

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic int at_least_one(input int v);
        return (v < 1) ? 1 : v;
    endfunction

    function automatic int frame_bits(input logic [1:0] code);
        return 32 >> code;              // 32, 16, 8, 4
    endfunction

    function automatic spi_word_t low_bits(input spi_word_t w, input int n);
        return (n >= 32) ? w : (w & ((32'd1 << n) - 1));
    endfunction

    task automatic check_word(input string name, input spi_word_t exp, input spi_word_t act);
        assert (act === exp) else begin
            $display("ERR %s: expected %08h, actual %08h", name, exp, act);
            data_errs++;
        end
    endtask

    task automatic check_int(input string name, input int exp, input int act);
        assert (act == exp) else begin
            $display("ERR %s: expected %0d, actual %0d", name, exp, act);
            timing_errs++;
        end
    endtask

    task automatic end_run();
        $display("errors: %0d data, %0d timing, %0d timeouts", data_errs, timing_errs, timeouts);
        if (data_errs == 0 && timing_errs == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic wait_busy(input logic level, input int limit, input int idx);
        int n;
        n = 0;
        while (busy !== level && n < limit) begin
            @(posedge gclk);
            n++;
        end
        if (busy !== level) begin
            $display("row %0d: busy_o did not go %0s within %0d cycles",
                     idx, level ? "high" : "low", limit);
            timeouts++;
        end
    endtask

    //////////////////////////////
    // slave model
    //////////////////////////////

    always @(posedge gclk) begin
        if (cs) begin
            miso    <= cur_reply[cur_bits-1];       // first bit ready before cs falls
            tx_left <= cur_cpha ? cur_bits : cur_bits - 1;
        end else if (sclk != sclk_d) begin
            // drive on the edge that leaves idle only with phase 1
            if ((sclk != cur_cpol) == cur_cpha) begin
                if (tx_left > 0) miso <= cur_reply[tx_left-1];
                tx_left <= tx_left - 1;
            end else begin
                slave_rx <= {slave_rx[30:0], mosi};
            end
        end
        if (cs_d && !cs) slave_rx <= '0;
    end

    //////////////////////////////
    // bus monitor
    //////////////////////////////

    // every event is seen one cycle late, so the differences stay exact
    always @(posedge gclk) begin
        cyc    <= cyc + 1;
        cs_d   <= cs;
        sclk_d <= sclk;
        if (nrst) begin
            if (cs_d && !cs) begin
                frames_seen <= frames_seen + 1;
                fall_cyc    <= cyc;
                edges_seen  <= 0;
                if (rise_seen) begin
                    assert (cyc - rise_cyc >= cur_ifg + 1) else begin
                        $display("ERR frame %0d gap: expected at least %0d, actual %0d",
                                 frames_seen + 1, cur_ifg + 1, cyc - rise_cyc);
                        timing_errs++;
                    end
                end
            end
            if (!cs && sclk != sclk_d) begin
                if (edges_seen == 0) begin
                    check_int($sformatf("frame %0d cs to sck", frames_seen),
                              cur_lead, cyc - fall_cyc);
                end else begin
                    check_int($sformatf("frame %0d half period", frames_seen),
                              cur_half, cyc - last_edge_cyc);
                end
                edges_seen    <= edges_seen + 1;
                last_edge_cyc <= cyc;
            end else if (!cs && !cs_d && edges_seen == 0) begin
                check_int($sformatf("frame %0d sck idle level", frames_seen), cur_cpol, sclk);
            end
            if (!cs_d && cs) begin
                check_int($sformatf("frame %0d sck to cs", frames_seen),
                          cur_lag, cyc - last_edge_cyc);
                check_int($sformatf("frame %0d edge count", frames_seen),
                          2 * cur_bits, edges_seen);
                rise_cyc  <= cyc;
                rise_seen <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic run_row(input int idx);
        vec_t v;
        int   n;
        int   extra;
        v     = vec_tbl[idx];
        n     = frame_bits(v.len);
        extra = $urandom % 40 + 1;
        if (start) begin
            start <= 1'b0;              // a held start needs a low cycle first
            @(posedge gclk);
        end
        spi_mode  <= v.mode;
        sck_speed <= v.rate;
        word_len  <= v.len;
        ifg       <= v.ifg;
        cs_sck    <= v.cs_sck;
        sck_cs    <= v.sck_cs;
        mosi_data <= v.mosi_word;
        start     <= 1'b1;
        cur_cpol  <= v.mode[1];
        cur_cpha  <= v.mode[0];
        cur_bits  <= n;
        cur_half  <= v.half;
        cur_ifg   <= v.ifg;
        cur_lead  <= at_least_one(v.cs_sck);
        cur_lag   <= at_least_one(v.sck_cs);
        cur_reply <= v.reply_word;
        wait_busy(1'b1, 400, idx);
        if (timeouts == 0) begin
            repeat (extra) @(posedge gclk);
            start <= 1'b0;
            @(posedge gclk);
            start <= 1'b1;              // second rising edge while busy
            check_int($sformatf("row %0d busy at second start", idx), 1, busy);
            @(posedge gclk);
            if (idx % 2 == 0) start <= 1'b0;  // odd rows keep start high
            wait_busy(1'b0, 6000, idx);
        end
        if (timeouts == 0) begin
            check_word($sformatf("row %0d miso_data_o", idx), v.exp_rx, miso_data);
            check_word($sformatf("row %0d slave mosi word", idx),
                       low_bits(v.mosi_word, n), slave_rx);
            check_int($sformatf("row %0d frame count", idx), idx + 1, frames_seen);
        end
    endtask

    initial begin
        gclk          = 1'b0;
        nrst          = 1'b0;
        start         = 1'b0;
        spi_mode      = 2'd0;
        sck_speed     = 2'd0;
        word_len      = 2'd0;
        ifg           = '0;
        cs_sck        = '0;
        sck_cs        = '0;
        mosi_data     = '0;
        miso          = 1'b0;
        cur_cpol      = 1'b0;
        cur_cpha      = 1'b0;
        cur_bits      = 32;
        cur_half      = 0;
        cur_ifg       = 0;
        cur_lead      = 1;
        cur_lag       = 1;
        cur_reply     = '0;
        data_errs     = 0;
        timing_errs   = 0;
        timeouts      = 0;
        cs_d          = 1'b1;
        sclk_d        = 1'b0;
        cyc           = 0;
        fall_cyc      = 0;
        rise_cyc      = 0;
        rise_seen     = 1'b0;
        last_edge_cyc = 0;
        edges_seen    = 0;
        frames_seen   = 0;
        tx_left       = 0;
        slave_rx      = '0;
        void'($urandom(32'hd833_a1f3));
        load_vectors();

        repeat (8) @(posedge gclk);
        nrst <= 1'b1;
        @(posedge gclk);
        check_int("reset cs_o", 1, cs);
        check_int("reset busy_o", 0, busy);
        check_int("reset mosi_o", 0, mosi);
        check_int("reset sclk_o", 0, sclk);
        check_word("reset miso_data_o", '0, miso_data);

        for (int i = 0; i < NUM_VEC && timeouts == 0; i++) begin
            run_row(i);
        end

        if (timeouts == 0) begin
            @(posedge gclk);
            start <= 1'b0;
            repeat (400) @(posedge gclk);   // long enough for any stray frame to show
            check_int("total frame count", NUM_VEC, frames_seen);
        end
        end_run();
    end

endmodule
